// File: attributeRegs.sv
`timescale 1ns/1ps

module attributeRegs (
  input  logic             CLK_24,
  input  logic             RESET_INT,
  input  ulaPkg::heldByteT heldByte,
  input  logic             isAttrib,
  input  logic             writeStrobe,
  rasterIf.reader          raster,
  modeIf.source            mode
);
  import ulaPkg::*;

  rgbT        inkReg;
  rgbT        paperReg;
  logic [2:0] styleReg;
  logic [2:1] modeBits;  // Mode bit 0 has no function

  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) begin
      inkReg   <= 3'b111;
      styleReg <= '0;
      paperReg <= '0;
      modeBits <= '0;  // 60 Hz text
    end else if (raster.reloadSel) begin
      // Line start defaults, mode survives
      inkReg   <= 3'b111;
      styleReg <= '0;
      paperReg <= '0;
    end else if (writeStrobe && isAttrib && raster.blankingN) begin
      case (heldByte.attr.cmd)
        4'd0:    inkReg   <= heldByte.attr.value;
        4'd1:    styleReg <= heldByte.attr.value;
        4'd2:    paperReg <= heldByte.attr.value;
        4'd3:    modeBits <= heldByte.attr.value[2:1];
        default: ;  // Other commands ignored
      endcase
    end
  end

  assign mode.ink       = inkReg;
  assign mode.paper     = paperReg;
  assign mode.altSel    = styleReg[0];
  assign mode.dblHgtSel = styleReg[1];
  assign mode.flashSel  = styleReg[2];
  assign mode.freqSel   = modeBits[1];   // 1 = 50 Hz
  assign mode.hiresSel  = modeBits[2];

endmodule

// File: memoryAddressMux.sv
`timescale 1ns/1ps

module memoryAddressMux (
  input  logic        CLK_24,
  input  logic [15:0] ADDR,
  input  logic        MAPn,
  input  logic [7:0]  dataByte,
  seqIf.reader        seq,
  rasterIf.reader     raster,
  modeIf.reader       mode,
  output logic        CSRAMn,
  output logic        CSIOn,
  output logic        CSROMn,
  output logic [15:0] sramAddr
);
  import ulaPkg::*;

  logic        hiresEff;
  logic        dblHgtEn;
  logic [8:0]  rowIdx;    // Screen row, lines or text rows
  logic [15:0] mulBy40;
  logic [15:0] vap1;
  logic [5:0]  fontBank;
  logic [2:0]  charRow;
  logic [15:0] vap2;
  logic        ioHit;
  logic        romArea;

  assign hiresEff = mode.hiresSel & ~raster.forceText;
  assign dblHgtEn = mode.dblHgtSel & ~hiresEff;

  //////////////////////////////////////////////////
  // Phase 1, screen byte
  //////////////////////////////////////////////////
  assign rowIdx  = hiresEff ? raster.vCount : {3'b000, raster.vCount[8:3]};
  assign mulBy40 = {2'b00, rowIdx, 5'b0} + {4'b0000, rowIdx, 3'b0};  // x32 + x8
  assign vap1    = (hiresEff ? hiresBase : textBase) + mulBy40 + {9'd0, raster.hCount};

  // Phase 2, charset row
  always_comb begin
    case ({mode.hiresSel, mode.altSel})
      2'b11:   fontBank = 6'b100111;  // 9Cxx
      2'b10:   fontBank = 6'b100110;  // 98xx
      2'b01:   fontBank = 6'b101110;  // B8xx
      default: fontBank = 6'b101101;  // B4xx
    endcase
  end

  assign charRow = dblHgtEn ? raster.vCount[3:1] : raster.vCount[2:0];
  assign vap2    = {fontBank, dataByte[6:0], charRow};

  // Address latch, one source per phase
  always_ff @(posedge CLK_24) begin
    if (seq.vap1Load) sramAddr <= vap1;
    else if (seq.vap2Load) sramAddr <= vap2;
    else if (seq.cpuLatch) sramAddr <= ADDR;
  end

  //////////////////////////////////////////////////
  // Chip selects, active only in PHI2
  //////////////////////////////////////////////////
  assign ioHit   = ADDR[15:8] == ioPage;
  assign romArea = &ADDR[15:14];           // C000..FFFF

  assign CSIOn  = ~(seq.phi2 & ioHit);
  assign CSROMn = ~(seq.phi2 & romArea & MAPn);
  assign CSRAMn = ~(seq.phi2 & ((romArea & ~MAPn) |    // Overlay RAM
                                (~romArea & ~ioHit)));

endmodule

// File: oricUla.f
ulaPkg.sv
ulaIfs.sv
ulaSequencer.sv
rasterTiming.sv
attributeRegs.sv
pixelSerializer.sv
memoryAddressMux.sv
oricUla.sv
ulaChecker.sv
oricUlaTb.sv

// File: oricUla.sv
`timescale 1ns/1ps

module oricUla #(
  parameter int flashCountWidth = 5
) (
  input  logic        CLK_24,
  input  logic        RESET_INT,
  input  logic        RW,        // Pin compatibility only
  input  logic        MAPn,
  input  logic [7:0]  DB,
  input  logic [15:0] ADDR,
  output logic        PHI2,
  output logic        CSRAMn,
  output logic        CSIOn,
  output logic        CSROMn,
  output logic [15:0] SRAM_AD,
  output logic        R,
  output logic        G,
  output logic        B,
  output logic        SYNC,
  output logic        HSYNC,
  output logic        VSYNC
);
  import ulaPkg::*;

  seqIf    seqBus ();
  rasterIf rasterBus ();
  modeIf   modeBus ();

  heldByteT   heldByte;
  logic       isAttrib;
  logic       writeStrobe;
  logic [7:0] dataByte;
  rgbT        rgb;

  ulaSequencer u_ulaSequencer (
    .CLK_24, .RESET_INT, .seq(seqBus)
  );

  rasterTiming #(.flashCountWidth(flashCountWidth)) u_rasterTiming (
    .CLK_24, .RESET_INT, .seq(seqBus), .mode(modeBus), .raster(rasterBus)
  );

  attributeRegs u_attributeRegs (
    .CLK_24, .RESET_INT, .heldByte, .isAttrib, .writeStrobe,
    .raster(rasterBus), .mode(modeBus)
  );

  pixelSerializer u_pixelSerializer (
    .CLK_24, .RESET_INT, .DB, .seq(seqBus), .raster(rasterBus), .mode(modeBus),
    .heldByte, .isAttrib, .writeStrobe, .dataByte, .rgb
  );

  memoryAddressMux u_memoryAddressMux (
    .CLK_24, .ADDR, .MAPn, .dataByte, .seq(seqBus), .raster(rasterBus),
    .mode(modeBus), .CSRAMn, .CSIOn, .CSROMn, .sramAddr(SRAM_AD)
  );

  // Pins
  assign PHI2  = seqBus.phi2;
  assign HSYNC = rasterBus.hsyncN;
  assign VSYNC = rasterBus.vsyncN;
  assign SYNC  = ~(rasterBus.hsyncN ^ rasterBus.vsyncN);  // Composite
  assign R     = rgb[0];
  assign G     = rgb[1];
  assign B     = rgb[2];

endmodule

// File: oricUlaTb.sv
`timescale 1ns/1ps

module oricUlaTb;

  //////////////////////////////////////////////////
  // Run limit from frame lengths
  //////////////////////////////////////////////////
  localparam int lineClks = 64 * 24;        // 64 CPU cycles of 24 clocks
  localparam int frame60  = 261 * lineClks;
  localparam int frame50  = 313 * lineClks;
  // Two frames per rate, whole millions plus two for margin
  localparam int timeoutCycles = ((2 * frame60 + 2 * frame50) / 1_000_000 + 2) * 1_000_000;

  logic        CLK_24;
  logic        RESET_INT;
  logic        RW;
  logic        MAPn;
  logic [7:0]  DB;
  logic [15:0] ADDR;
  logic        PHI2;
  logic        CSRAMn;
  logic        CSIOn;
  logic        CSROMn;
  logic [15:0] SRAM_AD;
  logic        R;
  logic        G;
  logic        B;
  logic        SYNC;
  logic        HSYNC;
  logic        VSYNC;
  int          testId;
  int          doneId;
  int          errorCount;
  bit          summaryDone;
  int          cycleCount = 0;

  oricUla #(.flashCountWidth(5)) u_oricUla (
    .CLK_24, .RESET_INT, .RW, .MAPn, .DB, .ADDR, .PHI2, .CSRAMn, .CSIOn, .CSROMn,
    .SRAM_AD, .R, .G, .B, .SYNC, .HSYNC, .VSYNC
  );

  ulaChecker u_ulaChecker (
    .CLK_24, .RESET_INT, .MAPn, .ADDR, .PHI2, .CSRAMn, .CSIOn, .CSROMn, .SRAM_AD,
    .rgb({B, G, R}), .SYNC, .HSYNC, .VSYNC, .testId, .doneId, .errorCount, .summaryDone
  );

  initial begin
    CLK_24 = 1'b0;
    forever #50 CLK_24 = ~CLK_24;  // 100 ns
  end

  always @(posedge CLK_24) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == timeoutCycles) begin
      $display("Timeout: test %0d did not finish within %0d cycles", testId, timeoutCycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Returns at the edge that ends state 0
  task automatic alignToCycle();
    do begin
      @(posedge CLK_24);
    end while (!PHI2);
    do begin
      @(posedge CLK_24);
    end while (PHI2);
  endtask

  task automatic waitForTest(input int id);
    while (doneId != id) @(posedge CLK_24);
  endtask

  // Weighted toward the I/O page and the ROM area
  task automatic driveRandomAddress();
    logic [15:0] addr;
    addr = 16'($urandom);
    case ($urandom_range(3, 0))
      0:       addr[15:8] = 8'h03;
      1:       addr[15:14] = 2'b11;
      default: ;
    endcase
    ADDR <= addr;
    MAPn <= 1'($urandom);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  initial begin
    RESET_INT = 1'b1;
    RW        = 1'b1;
    MAPn      = 1'b1;
    DB        = 8'h40;     // Plain data cell, never an attribute
    ADDR      = 16'h0400;
    testId    = 1;
    void'($urandom(32'he41a));
    repeat (8) @(posedge CLK_24);
    RESET_INT <= 1'b0;
    waitForTest(1);

    testId <= 2;
    alignToCycle();
    repeat (200) begin
      driveRandomAddress();  // Held for one CPU cycle
      alignToCycle();
    end

    ADDR   <= 16'h0400;
    testId <= 3;
    waitForTest(3);
    DB     <= 8'h14;       // Paper attribute, blue
    testId <= 4;
    waitForTest(4);
    DB     <= 8'h1A;       // Mode attribute, 50 Hz text
    testId <= 5;
    waitForTest(5);

    testId <= 0;
    while (!summaryDone) @(posedge CLK_24);
    if (errorCount == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: pixelSerializer.sv
`timescale 1ns/1ps

module pixelSerializer (
  input  logic              CLK_24,
  input  logic              RESET_INT,
  input  logic [7:0]        DB,
  seqIf.reader              seq,
  rasterIf.reader           raster,
  modeIf.reader             mode,
  output ulaPkg::heldByteT  heldByte,
  output logic              isAttrib,
  output logic              writeStrobe,
  output logic [7:0]        dataByte,
  output ulaPkg::rgbT       rgb
);
  import ulaPkg::*;

  logic [2:0] cellStep;  // pixelEn count since vap1Load
  logic       invHold;
  logic       invCell;   // Inverse for the cell on screen
  logic       hiresEff;
  logic       loadHold;
  logic [5:0] shifter;
  logic       pixelBit;
  rgbT        colour;

  assign hiresEff = mode.hiresSel & ~raster.forceText;

  // Data bus capture, phase 1 and phase 2
  always_ff @(posedge CLK_24) begin
    if (seq.dataBusEn) dataByte <= DB;
  end

  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) begin
      isAttrib <= 1'b0;
      invHold  <= 1'b0;
      cellStep <= '0;
    end else begin
      if (seq.attribDec) begin
        isAttrib <= ~|DB[6:5];  // 00x xxxx is an attribute
        invHold  <= DB[7];
      end
      if (seq.vap1Load) cellStep <= '0;
      else if (seq.pixelEn) cellStep <= cellStep + 3'd1;
    end
  end

  // Hires pixels at state 5, attributes at 9, font row at 13
  assign loadHold = seq.pixelEn &
                    ((~isAttrib & hiresEff & (cellStep == 3'd1)) |
                     (isAttrib & (cellStep == 3'd2)) |
                     (~isAttrib & ~hiresEff & (cellStep == 3'd3)));

  always_ff @(posedge CLK_24) begin
    if (loadHold) heldByte <= dataByte[6:0];
  end

  //////////////////////////////////////////////////
  // Shifter, 6 pixels per cell
  //////////////////////////////////////////////////
  always_ff @(posedge CLK_24) begin
    if (seq.pixelEn) begin
      if (seq.reloadReg && !isAttrib) shifter <= heldByte.data.pixels;
      else shifter <= {shifter[4:0], 1'b0};  // Attribute cell shows paper
      if (seq.reloadReg) invCell <= invHold;
    end
  end

  assign writeStrobe = seq.reloadReg;  // Attribute write slot

  assign pixelBit = (raster.flashClk & mode.flashSel) ? 1'b0 : shifter[5];  // Flash off
  assign colour   = pixelBit ? mode.ink : mode.paper;

  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) rgb <= '0;
    else if (!raster.blankingN) rgb <= '0;       // Black outside the window
    else rgb <= invCell ? ~colour : colour;
  end

endmodule

// File: rasterTiming.sv
`timescale 1ns/1ps

module rasterTiming #(
  parameter int flashCountWidth = 5
) (
  input  logic    CLK_24,
  input  logic    RESET_INT,
  seqIf.reader    seq,
  modeIf.reader   mode,
  rasterIf.source raster
);
  import ulaPkg::*;

  logic [6:0]                 hCount;
  logic [8:0]                 vCount;
  logic [8:0]                 vLast;
  logic [flashCountWidth-1:0] flashCnt;  // Frame counter
  logic                       hVis;
  logic                       vVis;

  assign vLast = mode.freqSel ? vLast50 : vLast60;

  //////////////////////////////////////////////////
  // Counters, one step per CPU cycle
  //////////////////////////////////////////////////
  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) begin
      hCount   <= '0;
      vCount   <= '0;
      flashCnt <= '0;
    end else if (seq.cpuBusEn) begin
      if (hCount == hLast) begin
        hCount <= '0;
        // End of line
        if (vCount >= vLast) begin  // Also catches a switch 50 -> 60 Hz
          vCount   <= '0;
          flashCnt <= flashCnt + 1'b1;
        end else begin
          vCount <= vCount + 9'd1;
        end
      end else begin
        hCount <= hCount + 7'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Timing levels
  //////////////////////////////////////////////////
  assign hVis = (hCount >= hVisFirst) && (hCount <= hVisLast);
  assign vVis = vCount < vBlankFirst;

  assign raster.hCount    = hCount;
  assign raster.vCount    = vCount;
  assign raster.hsyncN    = ~((hCount >= hSyncFirst) && (hCount <= hSyncLast));
  assign raster.vsyncN    = mode.freqSel ?
                            ~((vCount >= vSync50First) && (vCount <= vSync50Last)) :
                            ~((vCount >= vSync60First) && (vCount <= vSync60Last));
  assign raster.blankingN = hVis & vVis;
  assign raster.reloadSel = hCount >= reloadFirst;
  assign raster.forceText = vCount >= textForceFirst;
  assign raster.flashClk  = flashCnt[flashCountWidth-1];  // Half period 2^(w-1) frames

  hCountRange: assert property (@(posedge CLK_24) disable iff (RESET_INT)
    hCount <= hLast);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the ULA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module oricUlaTb -f oricUla.f -o oricUlaSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/oricUlaSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' sim.log; then
  exit 1
fi
exit 0

// File: ulaChecker.sv
`timescale 1ns/1ps

module ulaChecker (
  input  logic        CLK_24,
  input  logic        RESET_INT,
  input  logic        MAPn,
  input  logic [15:0] ADDR,
  input  logic        PHI2,
  input  logic        CSRAMn,
  input  logic        CSIOn,
  input  logic        CSROMn,
  input  logic [15:0] SRAM_AD,
  input  logic [2:0]  rgb,          // {B, G, R}
  input  logic        SYNC,
  input  logic        HSYNC,
  input  logic        VSYNC,
  input  int          testId,       // 0 closes the run
  output int          doneId,
  output int          errorCount,
  output bit          summaryDone
);

  int    curTest;
  int    checks;
  int    testErrs;
  int    testsRun;
  int    testsBad;
  int    totalErrs;
  int    clkCount;
  int    lines;           // HSYNC falls in test 4
  int    linesAfterBlue;
  bit    blueSeen;
  logic  syncRef;
  int    lastFall [3];    // Clock of last falling edge, -1 for none
  int    measured [3];    // Full periods seen
  logic  level [3];
  logic  prevLevel [3];
  string sigNames [3] = '{"PHI2", "HSYNC", "VSYNC"};

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  // {CSRAMn, CSIOn, CSROMn} from the CPU memory map
  function automatic logic [2:0] expectedSelects(input logic [15:0] addr, input logic mapN,
                                                 input logic phi2);
    if (!phi2) return 3'b111;                     // Nothing selected outside PHI2
    if (addr[15:8] == 8'h03) return 3'b101;       // I/O page
    if (addr >= 16'hC000 && mapN) return 3'b110;  // ROM
    return 3'b011;                                // RAM, overlay included
  endfunction

  // Low time or period in clocks, 24 per CPU cycle, 64 cycles per line
  function automatic int windowClocks(input int sig, input bit period, input bit is50);
    case (sig)
      0:       return period ? 24 : 16;                          // PHI2
      1:       return period ? 64 * 24 : 5 * 24;                 // HSYNC
      default: return period ? (is50 ? 313 : 261) * 64 * 24 : 2 * 64 * 24;
    endcase
  endfunction

  function automatic string testName(input int id);
    case (id)
      1:       return "phi2_after_reset";
      2:       return "chip_selects";
      3:       return "sync_60hz";
      4:       return "paper_blue";
      5:       return "frame_50hz";
      default: return "idle";
    endcase
  endfunction

  task reportMismatch(input string what, input int expected, input int actual);
    $display("Mismatch %s %s: expected %0d (0x%0h), actual %0d (0x%0h)",
             testName(curTest), what, expected, expected, actual, actual);
    testErrs++;
  endtask

  task closeTest();
    $display("Test %0d %s: %0d checks, %0d errors", curTest, testName(curTest), checks, testErrs);
    testsRun++;
    totalErrs += testErrs;
    if (testErrs != 0) testsBad++;
  endtask

  //////////////////////////////////////////////////
  // Compare, on pre-edge values
  //////////////////////////////////////////////////
  always @(posedge CLK_24) begin
    clkCount++;
    if (testId != curTest) begin
      if (curTest != 0) closeTest();
      curTest        = testId;
      checks         = 0;
      testErrs       = 0;
      lines          = 0;
      linesAfterBlue = 0;
      blueSeen       = 1'b0;
      for (int i = 0; i < 3; i++) begin
        lastFall[i] = -1;  // No edge timing across tests
        measured[i] = 0;
      end
      if (curTest == 0) begin
        $display("Summary: %0d tests, %0d clean, %0d with errors, %0d errors in total",
                 testsRun, testsRun - testsBad, testsBad, totalErrs);
        errorCount  <= totalErrs;
        summaryDone <= 1'b1;
      end
    end

    syncRef = ~(HSYNC ^ VSYNC);  // Composite sync
    if (curTest != 0 && RESET_INT) begin
      checks++;
      if ({PHI2, CSRAMn, CSIOn, CSROMn, HSYNC, VSYNC, rgb} != 9'h0F8)
        reportMismatch("reset pins {PHI2,CS,HSYNC,VSYNC,RGB}", 'h0F8,
                       int'({PHI2, CSRAMn, CSIOn, CSROMn, HSYNC, VSYNC, rgb}));
    end else if (curTest != 0) begin
      checks++;
      if ({CSRAMn, CSIOn, CSROMn} != expectedSelects(ADDR, MAPn, PHI2))
        reportMismatch("chip selects {RAM,IO,ROM}", int'(expectedSelects(ADDR, MAPn, PHI2)),
                       int'({CSRAMn, CSIOn, CSROMn}));
      if (SYNC != syncRef) reportMismatch("SYNC", int'(syncRef), int'(SYNC));
      if (curTest == 2 && PHI2 && SRAM_AD != ADDR)
        reportMismatch("SRAM_AD", int'(ADDR), int'(SRAM_AD));

      if (curTest == 4) begin
        if (!HSYNC && rgb != 3'b000) reportMismatch("RGB in HSYNC", 0, int'(rgb));
        if (HSYNC && VSYNC && rgb == 3'b100) blueSeen = 1'b1;  // Blue only
        if (prevLevel[1] && !HSYNC) begin
          lines++;
          if (blueSeen) linesAfterBlue++;
          if (linesAfterBlue == 2) doneId <= 4;
          if (lines == 300 && !blueSeen) begin
            $display("Error in test 4 %s: no blue-only pixel within 300 lines", testName(4));
            testErrs++;
            doneId <= 4;
          end
        end
      end

      // Low time and period of PHI2, HSYNC, VSYNC
      level[0] = PHI2;
      level[1] = HSYNC;
      level[2] = VSYNC;
      for (int i = 0; i < 3; i++) begin
        if (prevLevel[i] && !level[i]) begin
          if (lastFall[i] >= 0) begin
            if (clkCount - lastFall[i] != windowClocks(i, 1'b1, curTest == 5))
              reportMismatch({sigNames[i], " period"}, windowClocks(i, 1'b1, curTest == 5),
                             clkCount - lastFall[i]);
            measured[i]++;
          end
          lastFall[i] = clkCount;
        end else if (!prevLevel[i] && level[i] && lastFall[i] >= 0) begin
          if (clkCount - lastFall[i] != windowClocks(i, 1'b0, curTest == 5))
            reportMismatch({sigNames[i], " low time"}, windowClocks(i, 1'b0, curTest == 5),
                           clkCount - lastFall[i]);
        end
        prevLevel[i] = level[i];
      end

      case (curTest)
        1:       if (measured[0] >= 4) doneId <= 1;        // Four CPU cycles
        3, 5:    if (measured[2] >= 1) doneId <= curTest;  // One whole frame
        default: ;
      endcase
    end
  end

endmodule

// File: ulaIfs.sv
`timescale 1ns/1ps

// Cycle strobes from the state ring
interface seqIf;
  logic phi2;       // CPU clock, high in states 16..23
  logic cpuLatch;   // State 15
  logic attribDec;  // State 3
  logic dataBusEn;  // States 2 and 10
  logic pixelEn;    // Every 4th state from 1
  logic reloadReg;  // State 17
  logic vap1Load;   // State 23
  logic vap2Load;   // State 7
  logic cpuBusEn;   // State 15, raster tick

  modport sequencer (output phi2, cpuLatch, attribDec, dataBusEn, pixelEn,
                     reloadReg, vap1Load, vap2Load, cpuBusEn);
  modport reader (input phi2, cpuLatch, attribDec, dataBusEn, pixelEn,
                  reloadReg, vap1Load, vap2Load, cpuBusEn);
endinterface

// Raster position and timing levels
interface rasterIf;
  logic [6:0] hCount;
  logic [8:0] vCount;
  logic       hsyncN;
  logic       vsyncN;
  logic       blankingN;  // High in the visible window
  logic       reloadSel;  // Attribute reload region
  logic       forceText;
  logic       flashClk;

  modport source (output hCount, vCount, hsyncN, vsyncN, blankingN, reloadSel,
                  forceText, flashClk);
  modport reader (input hCount, vCount, hsyncN, vsyncN, blankingN, reloadSel,
                  forceText, flashClk);
endinterface

// Decoded attribute state
interface modeIf;
  import ulaPkg::*;

  rgbT  ink;
  rgbT  paper;
  logic altSel;     // Alternate charset
  logic dblHgtSel;  // Double height
  logic flashSel;
  logic freqSel;    // 1 = 50 Hz
  logic hiresSel;

  modport source (output ink, paper, altSel, dblHgtSel, flashSel, freqSel, hiresSel);
  modport reader (input ink, paper, altSel, dblHgtSel, flashSel, freqSel, hiresSel);
endinterface

// File: ulaPkg.sv
package ulaPkg;

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////
  localparam int numStates = 24;  // CLK_24 states per CPU cycle
  localparam int phaseLen  = 8;   // States per memory phase

  //////////////////////////////////////////////////
  // Raster limits
  //////////////////////////////////////////////////
  localparam logic [6:0] hLast       = 7'd63;   // 64 CPU cycles per line
  localparam logic [8:0] vLast60     = 9'd260;  // 261 lines
  localparam logic [8:0] vLast50     = 9'd312;  // 313 lines
  localparam logic [6:0] hSyncFirst  = 7'd49;
  localparam logic [6:0] hSyncLast   = 7'd53;
  localparam logic [6:0] reloadFirst = 7'd49;   // Attribute reload up to end of line
  localparam logic [6:0] hVisFirst   = 7'd1;
  localparam logic [6:0] hVisLast    = 7'd40;   // 40 cells per line

  localparam logic [8:0] vSync60First   = 9'd241;
  localparam logic [8:0] vSync60Last    = 9'd242;
  localparam logic [8:0] vSync50First   = 9'd258;
  localparam logic [8:0] vSync50Last    = 9'd259;
  localparam logic [8:0] vBlankFirst    = 9'd224;
  localparam logic [8:0] textForceFirst = 9'd200;  // Bottom three text rows

  // Video memory
  localparam logic [15:0] hiresBase = 16'hA000;
  localparam logic [15:0] textBase  = 16'hBB80;
  localparam logic [7:0]  ioPage    = 8'h03;

  // Colour, R in bit 0 and B in bit 2
  typedef logic [2:0] rgbT;

  // Held video byte, attribute command or cell data
  typedef union packed {
    struct packed {
      logic [3:0] cmd;     // 0 ink, 1 style, 2 paper, 3 mode
      logic [2:0] value;
    } attr;
    struct packed {
      logic       spare;
      logic [5:0] pixels;  // Leftmost pixel in bit 5
    } data;
  } heldByteT;

endpackage

// File: ulaSequencer.sv
`timescale 1ns/1ps

module ulaSequencer (
  input  logic  CLK_24,
  input  logic  RESET_INT,
  seqIf.sequencer seq
);
  import ulaPkg::*;

  logic [numStates-1:0] state;  // One-hot, bit n = state n
  logic [2:0]           phase;  // Phase 1, 2, 3 (CPU)
  logic                 phaseEnd;

  // Last state of each phase
  assign phaseEnd = state[phaseLen-1] | state[2*phaseLen-1] | state[3*phaseLen-1];

  always_ff @(posedge CLK_24 or posedge RESET_INT) begin
    if (RESET_INT) begin
      state <= {{(numStates-1){1'b0}}, 1'b1};
      phase <= 3'b001;
    end else begin
      state <= {state[numStates-2:0], state[numStates-1]};  // Rotate
      if (phaseEnd) phase <= {phase[1:0], phase[2]};
    end
  end

  assign seq.phi2      = phase[2];                  // CPU owns phase 3
  assign seq.cpuLatch  = state[15];
  assign seq.cpuBusEn  = state[15];
  assign seq.attribDec = state[3];
  assign seq.dataBusEn = state[2] | state[10];      // Video data, both fetches
  assign seq.pixelEn   = state[1] | state[5] | state[9] | state[13] | state[17] | state[21];
  assign seq.reloadReg = state[17];
  assign seq.vap1Load  = state[23];                 // Ahead of phase 1
  assign seq.vap2Load  = state[7];                  // Ahead of phase 2

  // Both rings must keep exactly one token
  ringOneHot: assert property (@(posedge CLK_24) disable iff (RESET_INT)
    $onehot(state) && $onehot(phase));

endmodule
